// File: rtl/ice_pkg.sv
package ice_pkg;

	// One byte on the UART, the master bus or a frame field
	typedef logic [7:0] ice_byte_t;

	// Slave data word
	// bit 8 flags the last word of a response
	typedef logic [8:0] sl_word_t;

	// Clock cycles per UART bit
	typedef logic [15:0] baud_div_t;

	// Host command codes
	localparam ice_byte_t CMD_VERSION = "V";
	localparam ice_byte_t CMD_BAUD = "b";
	localparam ice_byte_t CMD_GPIO_OUT = "O";
	localparam ice_byte_t CMD_GPIO_INT = "I";
	localparam ice_byte_t CMD_GPIO_READ = "i";

	// Solicited response codes
	localparam ice_byte_t RSP_ACK = 8'h00;
	localparam ice_byte_t RSP_NAK = 8'h01;

	// Unsolicited message types
	localparam ice_byte_t MSG_GPIO = "g";

	// Version reply payload
	localparam ice_byte_t VERSION_MAJOR = 8'h00;
	localparam ice_byte_t VERSION_MINOR = 8'h05;

	// True for every command some responder handles
	function automatic logic is_known_cmd(input ice_byte_t cmd);
		return cmd inside {CMD_VERSION, CMD_BAUD, CMD_GPIO_OUT, CMD_GPIO_INT,
			CMD_GPIO_READ};
	endfunction

endpackage

// File: rtl/uart.sv
module uart
	import ice_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  baud_div_t baud_div,
	input  logic      rx_in,
	output logic      tx_out,
	input  logic      tx_latch,
	input  ice_byte_t tx_data,
	output logic      tx_empty,
	output ice_byte_t rx_data,
	output logic      rx_latch
);
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t rx_state;
	logic rx_meta;
	logic rx_sync;
	baud_div_t rx_cnt;
	logic [2:0] rx_bit;
	ice_byte_t rx_shift;
	baud_div_t tx_cnt;
	logic [3:0] tx_bit;
	logic [9:0] tx_shift;

	// Line is asynchronous to clk
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
		end
	end

	// Receiver, counts down to the middle of each bit
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_shift <= '0;
			rx_data <= '0;
			rx_latch <= 1'b0;
		end else begin
			rx_latch <= 1'b0;
			if (rx_state == RX_IDLE) begin
				// Start edge, wait half a bit
				if (!rx_sync) begin
					rx_cnt <= baud_div >> 1;
					rx_state <= RX_START;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= baud_div - 1'b1;
				case (rx_state)
					// Glitch if the start bit is gone at mid-bit
					RX_START: rx_state <= rx_sync ? RX_IDLE : RX_DATA;
					RX_DATA: begin
						// LSB first
						rx_shift <= {rx_sync, rx_shift[7:1]};
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
					default: begin
						// Framing error drops the byte
						rx_data <= rx_shift;
						rx_latch <= rx_sync;
						rx_state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// Transmitter, start + 8 data + stop
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_empty <= 1'b1;
			tx_shift <= '1;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_cnt <= baud_div - 1'b1;
				tx_bit <= '0;
				tx_empty <= 1'b0;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else begin
			// Shift in ones so the line idles high
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_cnt <= baud_div - 1'b1;
			tx_bit <= tx_bit + 1'b1;
			if (tx_bit == 4'd9)
				tx_empty <= 1'b1;
		end
	end

	assign tx_out = tx_shift[0];

	// Framer must respect back-pressure
	a_tx_latch_when_empty: assert property (@(posedge clk) disable iff (reset)
		tx_latch |-> tx_empty);

endmodule

// File: rtl/ice_bus_controller.sv
module ice_bus_controller
	import ice_pkg::*;
#(
	parameter int NUM_DEV = 2,
	parameter int RESP_DEPTH = 16
) (
	input  logic               clk,
	input  logic               reset,
	input  ice_byte_t          rx_char,
	input  logic               rx_char_valid,
	output ice_byte_t          tx_char,
	output logic               tx_char_valid,
	input  logic               tx_char_ready,
	output logic               generate_nak,
	output ice_byte_t          ma_addr,
	output ice_byte_t          ma_data,
	output logic               ma_data_valid,
	output logic               ma_frame_valid,
	input  ice_byte_t          sl_addr,
	input  sl_word_t           sl_data,
	input  logic               sl_data_latch,
	input  logic [NUM_DEV-1:0] sl_arb_request,
	output logic [NUM_DEV-1:0] sl_arb_grant
);
	localparam int AW = $clog2(RESP_DEPTH);
	localparam int CW = $clog2(RESP_DEPTH + 1);

	typedef enum logic [2:0] {P_CMD, P_EVT, P_LEN, P_DATA, P_END} parse_state_t;
	typedef enum logic [1:0] {F_IDLE, F_COLLECT, F_SEND} frm_state_t;

	parse_state_t p_state;
	frm_state_t f_state;
	ice_byte_t cmd_q;
	ice_byte_t evt_id;
	ice_byte_t remaining;
	ice_byte_t hdr_code;
	ice_byte_t hdr_evt;
	ice_byte_t async_cnt;
	ice_byte_t resp_buf [RESP_DEPTH];
	logic [CW-1:0] wcount;
	logic [CW:0] sidx;
	logic [CW:0] rd_ptr;
	logic [NUM_DEV-1:0] grant_next;

	// Frame parser, broadcasts on the master bus
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			p_state <= P_CMD;
			cmd_q <= '0;
			evt_id <= '0;
			remaining <= '0;
			ma_addr <= '0;
			ma_data <= '0;
			ma_data_valid <= 1'b0;
			ma_frame_valid <= 1'b0;
			generate_nak <= 1'b0;
		end else begin
			ma_data_valid <= 1'b0;
			generate_nak <= 1'b0;
			case (p_state)
				P_CMD: if (rx_char_valid) begin
					cmd_q <= rx_char;
					p_state <= P_EVT;
				end
				// Echoed in the solicited reply
				P_EVT: if (rx_char_valid) begin
					evt_id <= rx_char;
					p_state <= P_LEN;
				end
				P_LEN: if (rx_char_valid) begin
					ma_addr <= cmd_q;
					remaining <= rx_char;
					ma_frame_valid <= 1'b1;
					p_state <= (rx_char == '0) ? P_END : P_DATA;
				end
				P_DATA: if (rx_char_valid) begin
					ma_data <= rx_char;
					ma_data_valid <= 1'b1;
					remaining <= remaining - 1'b1;
					if (remaining == 8'd1)
						p_state <= P_END;
				end
				default: begin
					// Frame end, nobody answers unknown commands
					ma_frame_valid <= 1'b0;
					generate_nak <= !is_known_cmd(ma_addr);
					p_state <= P_CMD;
				end
			endcase
		end
	end

	// Fixed priority, lowest index wins
	always_comb begin
		grant_next = '0;
		for (int i = NUM_DEV - 1; i >= 0; i--) begin
			if (sl_arb_request[i])
				grant_next = NUM_DEV'(1) << i;
		end
	end

	// Arbiter and framer
	// buffer holds the length word then the payload
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			f_state <= F_IDLE;
			sl_arb_grant <= '0;
			wcount <= '0;
			sidx <= '0;
			hdr_code <= '0;
			hdr_evt <= '0;
			async_cnt <= '0;
		end else begin
			case (f_state)
				F_IDLE: begin
					wcount <= '0;
					sidx <= '0;
					if (|sl_arb_request) begin
						sl_arb_grant <= grant_next;
						f_state <= F_COLLECT;
					end
				end
				F_COLLECT: if (sl_data_latch) begin
					wcount <= wcount + 1'b1;
					hdr_code <= sl_addr;
					if (sl_data[8]) begin
						sl_arb_grant <= '0;
						f_state <= F_SEND;
						// ACK/NAK echo the command, anything else is unsolicited
						if (sl_addr == RSP_ACK || sl_addr == RSP_NAK) begin
							hdr_evt <= evt_id;
						end else begin
							hdr_evt <= async_cnt;
							async_cnt <= async_cnt + 1'b1;
						end
					end
				end
				default: if (tx_char_ready) begin
					sidx <= sidx + 1'b1;
					// Two header bytes plus the buffered words
					if (sidx == {1'b0, wcount} + 1'b1)
						f_state <= F_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (f_state == F_COLLECT && sl_data_latch)
			resp_buf[wcount[AW-1:0]] <= sl_data[7:0];
	end

	// Header bytes first, then the buffer
	always_comb begin
		rd_ptr = sidx - 2'd2;
		case (sidx)
			'd0: tx_char = hdr_code;
			'd1: tx_char = hdr_evt;
			default: tx_char = resp_buf[rd_ptr[AW-1:0]];
		endcase
	end

	assign tx_char_valid = (f_state == F_SEND) && tx_char_ready;

	// Only one responder owns the slave bus, and only while it asks
	a_grant_owner: assert property (@(posedge clk) disable iff (reset)
		$onehot0(sl_arb_grant) && ((sl_arb_grant & ~sl_arb_request) == '0));

	// Responders stay within the buffer
	a_resp_depth: assert property (@(posedge clk) disable iff (reset)
		(f_state == F_COLLECT && sl_data_latch) |-> (wcount < RESP_DEPTH));

endmodule

// File: rtl/basics_int.sv
module basics_int
	import ice_pkg::*;
#(
	parameter int GPIO_WIDTH = 8,
	parameter int DEFAULT_BAUD_DIV = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  generate_nak,
	input  ice_byte_t             ma_addr,
	input  ice_byte_t             ma_data,
	input  logic                  ma_data_valid,
	input  logic                  ma_frame_valid,
	output ice_byte_t             sl_addr,
	output sl_word_t              sl_data,
	output logic                  sl_data_latch,
	output logic                  sl_arb_request,
	input  logic                  sl_arb_grant,
	input  logic [GPIO_WIDTH-1:0] gpio_read,
	output logic [GPIO_WIDTH-1:0] gpio_level,
	output logic [GPIO_WIDTH-1:0] gpio_direction,
	output logic [GPIO_WIDTH-1:0] gpio_int_enable,
	output baud_div_t             uart_baud_div,
	input  logic                  uart_tx_empty
);
	// Code, event id and length of an empty ACK
	localparam logic [1:0] ACK_BYTES = 2'd3;

	logic fv_q;
	logic frame_end;
	ice_byte_t pcount;
	ice_byte_t p0;
	ice_byte_t p1;
	ice_byte_t rsp_code;
	ice_byte_t rsp_len;
	ice_byte_t rsp_b0;
	ice_byte_t rsp_b1;
	ice_byte_t word_byte;
	logic word_last;
	logic [1:0] widx;
	baud_div_t baud_pend;
	logic baud_wait;
	logic [1:0] fall_cnt;
	logic empty_q;

	assign frame_end = fv_q && !ma_frame_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			{fv_q, empty_q, baud_wait, sl_arb_request} <= 4'b0100;
			{pcount, p0, p1} <= '0;
			{rsp_code, rsp_len, rsp_b0, rsp_b1} <= '0;
			{widx, fall_cnt} <= '0;
			{gpio_level, gpio_direction, gpio_int_enable} <= '0;
			baud_pend <= '0;
			uart_baud_div <= baud_div_t'(DEFAULT_BAUD_DIV);
		end else begin
			fv_q <= ma_frame_valid;
			empty_q <= uart_tx_empty;
			// Keep the first two payload bytes, count the rest
			if (ma_data_valid) begin
				if (pcount == 8'd0)
					p0 <= ma_data;
				if (pcount == 8'd1)
					p1 <= ma_data;
				pcount <= pcount + 1'b1;
			end else if (!ma_frame_valid) begin
				pcount <= '0;
			end
			if (frame_end) begin
				sl_arb_request <= 1'b1;
				widx <= '0;
				rsp_code <= RSP_ACK;
				rsp_len <= 8'd0;
				if (generate_nak) begin
					rsp_code <= RSP_NAK;
				end else begin
					case (ma_addr)
						CMD_VERSION: if (pcount == 8'd0) begin
							rsp_len <= 8'd2;
							rsp_b0 <= VERSION_MAJOR;
							rsp_b1 <= VERSION_MINOR;
						end else rsp_code <= RSP_NAK;
						// Big-endian divider, applied once the ACK is out
						CMD_BAUD: if (pcount == 8'd2) begin
							baud_pend <= {p0, p1};
							baud_wait <= 1'b1;
							fall_cnt <= '0;
						end else rsp_code <= RSP_NAK;
						CMD_GPIO_OUT: if (pcount == 8'd2) begin
							gpio_direction <= GPIO_WIDTH'(p0);
							gpio_level <= GPIO_WIDTH'(p1);
						end else rsp_code <= RSP_NAK;
						CMD_GPIO_INT: if (pcount == 8'd1) begin
							gpio_int_enable <= GPIO_WIDTH'(p0);
						end else rsp_code <= RSP_NAK;
						CMD_GPIO_READ: if (pcount == 8'd0) begin
							rsp_len <= 8'd1;
							rsp_b0 <= 8'(gpio_read);
						end else rsp_code <= RSP_NAK;
						// Unknown codes come with generate_nak
						default: ;
					endcase
				end
			end
			// One word per granted cycle
			if (sl_data_latch) begin
				widx <= widx + 1'b1;
				if (word_last)
					sl_arb_request <= 1'b0;
			end
			// Count ACK bytes started after our grant, switch when the last stops
			if (baud_wait) begin
				if (sl_arb_grant) begin
					fall_cnt <= '0;
				end else if (empty_q && !uart_tx_empty && fall_cnt != ACK_BYTES) begin
					fall_cnt <= fall_cnt + 1'b1;
				end else if (fall_cnt == ACK_BYTES && uart_tx_empty) begin
					uart_baud_div <= baud_pend;
					baud_wait <= 1'b0;
				end
			end
		end
	end

	// Length word, then up to two payload bytes
	always_comb begin
		case (widx)
			2'd0: word_byte = rsp_len;
			2'd1: word_byte = rsp_b0;
			default: word_byte = rsp_b1;
		endcase
	end

	assign word_last = ({6'd0, widx} == rsp_len);
	assign sl_data_latch = sl_arb_grant & sl_arb_request;
	// Idle responders drive zero onto the shared bus
	assign sl_data = sl_arb_grant ? {word_last, word_byte} : '0;
	assign sl_addr = sl_arb_grant ? rsp_code : '0;

endmodule

// File: rtl/gpio_int.sv
module gpio_int
	import ice_pkg::*;
#(
	parameter int GPIO_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	inout  wire  [GPIO_WIDTH-1:0] gpio,
	input  logic [GPIO_WIDTH-1:0] gpio_level,
	input  logic [GPIO_WIDTH-1:0] gpio_direction,
	input  logic [GPIO_WIDTH-1:0] gpio_int_enable,
	output logic [GPIO_WIDTH-1:0] gpio_read,
	output ice_byte_t             sl_addr,
	output sl_word_t              sl_data,
	output logic                  sl_data_latch,
	output logic                  sl_arb_request,
	input  logic                  sl_arb_grant
);
	logic [GPIO_WIDTH-1:0] gpio_meta;
	logic [GPIO_WIDTH-1:0] read_q;
	logic [GPIO_WIDTH-1:0] pin_change;
	logic widx;

	// Outputs drive the level, inputs float
	for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
		assign gpio[i] = gpio_direction[i] ? gpio_level[i] : 1'bz;
	end

	// Only enabled input pins raise a report
	assign pin_change = (gpio_read ^ read_q) & gpio_int_enable & ~gpio_direction;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			gpio_meta <= '0;
			gpio_read <= '0;
			read_q <= '0;
			sl_arb_request <= 1'b0;
			widx <= 1'b0;
		end else begin
			gpio_meta <= gpio;
			gpio_read <= gpio_meta;
			read_q <= gpio_read;
			if (sl_data_latch) begin
				widx <= ~widx;
				if (widx)
					sl_arb_request <= 1'b0;
			end
			// Pending report absorbs later changes
			if (|pin_change)
				sl_arb_request <= 1'b1;
		end
	end

	// Length 1, then the pad value sampled at send time
	assign sl_data_latch = sl_arb_grant & sl_arb_request;
	assign sl_addr = sl_arb_grant ? MSG_GPIO : '0;
	assign sl_data = !sl_arb_grant ? '0 : widx ? {1'b1, 8'(gpio_read)} : {1'b0, 8'd1};

endmodule

// File: rtl/ice_bus.sv
module ice_bus
	import ice_pkg::*;
#(
	parameter int NUM_DEV = 2,
	parameter int GPIO_WIDTH = 8,
	parameter int DEFAULT_BAUD_DIV = 16,
	parameter int RESP_DEPTH = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  uart_rx,
	output logic                  uart_tx,
	inout  wire  [GPIO_WIDTH-1:0] gpio
);
	logic reset_syn0;
	logic reset_syn1;

	// UART side
	ice_byte_t uart_rx_data;
	ice_byte_t uart_tx_data;
	logic uart_rx_latch;
	logic uart_tx_latch;
	logic uart_tx_empty;
	baud_div_t uart_baud_div;

	// Master bus
	logic ma_generate_nak;
	ice_byte_t ma_addr;
	ice_byte_t ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;

	// Slave bus, ORed from the responders
	ice_byte_t sl_addr;
	ice_byte_t bi_sl_addr;
	ice_byte_t gi_sl_addr;
	sl_word_t sl_data;
	sl_word_t bi_sl_data;
	sl_word_t gi_sl_data;
	logic sl_data_latch;
	logic bi_sl_latch;
	logic gi_sl_latch;
	logic bi_request;
	logic gi_request;
	logic [NUM_DEV-1:0] sl_arb_request;
	logic [NUM_DEV-1:0] sl_arb_grant;

	// GPIO settings
	logic [GPIO_WIDTH-1:0] gpio_read;
	logic [GPIO_WIDTH-1:0] gpio_level;
	logic [GPIO_WIDTH-1:0] gpio_direction;
	logic [GPIO_WIDTH-1:0] gpio_int_enable;

	// Reset asserts at once, releases on clk
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reset_syn0 <= 1'b1;
			reset_syn1 <= 1'b1;
		end else begin
			reset_syn0 <= 1'b0;
			reset_syn1 <= reset_syn0;
		end
	end

	assign sl_addr = bi_sl_addr | gi_sl_addr;
	assign sl_data = bi_sl_data | gi_sl_data;
	assign sl_data_latch = bi_sl_latch | gi_sl_latch;
	// Basics is index 0, GPIO index 1
	assign sl_arb_request = NUM_DEV'({gi_request, bi_request});

	uart u1 (
		.clk(clk), .reset(reset_syn1), .baud_div(uart_baud_div),
		.rx_in(uart_rx), .tx_out(uart_tx),
		.tx_latch(uart_tx_latch), .tx_data(uart_tx_data), .tx_empty(uart_tx_empty),
		.rx_data(uart_rx_data), .rx_latch(uart_rx_latch)
	);

	ice_bus_controller #(.NUM_DEV(NUM_DEV), .RESP_DEPTH(RESP_DEPTH)) ice1 (
		.clk(clk), .reset(reset_syn1),
		.rx_char(uart_rx_data), .rx_char_valid(uart_rx_latch),
		.tx_char(uart_tx_data), .tx_char_valid(uart_tx_latch), .tx_char_ready(uart_tx_empty),
		.generate_nak(ma_generate_nak), .ma_addr(ma_addr), .ma_data(ma_data),
		.ma_data_valid(ma_data_valid), .ma_frame_valid(ma_frame_valid),
		.sl_addr(sl_addr), .sl_data(sl_data), .sl_data_latch(sl_data_latch),
		.sl_arb_request(sl_arb_request), .sl_arb_grant(sl_arb_grant)
	);

	basics_int #(.GPIO_WIDTH(GPIO_WIDTH), .DEFAULT_BAUD_DIV(DEFAULT_BAUD_DIV)) bi0 (
		.clk(clk), .reset(reset_syn1),
		.generate_nak(ma_generate_nak), .ma_addr(ma_addr), .ma_data(ma_data),
		.ma_data_valid(ma_data_valid), .ma_frame_valid(ma_frame_valid),
		.sl_addr(bi_sl_addr), .sl_data(bi_sl_data), .sl_data_latch(bi_sl_latch),
		.sl_arb_request(bi_request), .sl_arb_grant(sl_arb_grant[0]),
		.gpio_read(gpio_read), .gpio_level(gpio_level),
		.gpio_direction(gpio_direction), .gpio_int_enable(gpio_int_enable),
		.uart_baud_div(uart_baud_div), .uart_tx_empty(uart_tx_empty)
	);

	gpio_int #(.GPIO_WIDTH(GPIO_WIDTH)) gi1 (
		.clk(clk), .reset(reset_syn1), .gpio(gpio),
		.gpio_level(gpio_level), .gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable), .gpio_read(gpio_read),
		.sl_addr(gi_sl_addr), .sl_data(gi_sl_data), .sl_data_latch(gi_sl_latch),
		.sl_arb_request(gi_request), .sl_arb_grant(sl_arb_grant[1])
	);

endmodule

// File: tb/ice_bus_tb.sv
module ice_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int GPIO_W = 8;
	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 10;
	localparam int START_BAUD = 16;
	localparam int NEW_BAUD = 12;
	localparam int WAIT_LIMIT = 4000;
	localparam logic [31:0] LFSR_SEED = 32'hd9c8;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// Codes as the host sees them on the wire
	localparam logic [7:0] C_VERSION = "V";
	localparam logic [7:0] C_BAUD = "b";
	localparam logic [7:0] C_GPIO_OUT = "O";
	localparam logic [7:0] C_GPIO_INT = "I";
	localparam logic [7:0] C_GPIO_READ = "i";
	localparam logic [7:0] C_UNKNOWN = "Z";
	localparam logic [7:0] C_MSG_GPIO = "g";
	localparam logic [7:0] C_ACK = 8'h00;
	localparam logic [7:0] C_NAK = 8'h01;
	localparam logic [7:0] VER_MAJOR = 8'h00;
	localparam logic [7:0] VER_MINOR = 8'h05;

	// Byte 0 code, 1 event id, 2 length, 3 to 5 payload
	typedef logic [5:0][7:0] frame_t;

	logic clk;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	wire [GPIO_W-1:0] gpio;
	logic [GPIO_W-1:0] pad_value;
	logic [GPIO_W-1:0] pad_drive;
	logic [7:0] dir_model;
	logic [7:0] level_model;
	logic [7:0] async_count;
	logic [31:0] lfsr_state;
	int bit_cycles;
	int sent_frames;
	int checked_frames;
	frame_t exp_q[$];
	frame_t got_q[$];

	ice_bus #(
		.NUM_DEV(2), .GPIO_WIDTH(GPIO_W), .DEFAULT_BAUD_DIV(START_BAUD), .RESP_DEPTH(16)
	) dut0 (
		.clk(clk), .reset(reset), .uart_rx(uart_rx), .uart_tx(uart_tx), .gpio(gpio)
	);

	// External pad drivers, only on pins the DUT leaves as inputs
	for (genvar i = 0; i < GPIO_W; i++) begin : g_pad_model
		assign gpio[i] = pad_drive[i] ? pad_value[i] : 1'bz;
	end

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic lsb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			r = {r[30:0], lsb};
		end
		return r;
	endfunction

	// Outputs read back their level, inputs show what the pad model drives
	function automatic logic [7:0] pad_model_value();
		return (level_model & dir_model) | (pad_value & ~dir_model);
	endfunction

	// Reference response for one command or one pin report
	function automatic frame_t expected_frame(input logic [7:0] cmd, input logic [7:0] evt,
		input int plen, input logic [7:0] pads, input logic [7:0] async_id);
		frame_t f;
		f = '0;
		f[0] = C_NAK;
		f[1] = evt;
		case (cmd)
			C_VERSION: if (plen == 0) begin
				f[0] = C_ACK;
				f[2] = 8'd2;
				f[3] = VER_MAJOR;
				f[4] = VER_MINOR;
			end
			C_BAUD, C_GPIO_OUT: if (plen == 2)
				f[0] = C_ACK;
			C_GPIO_INT: if (plen == 1)
				f[0] = C_ACK;
			C_GPIO_READ: if (plen == 0) begin
				f[0] = C_ACK;
				f[2] = 8'd1;
				f[3] = pads;
			end
			// Unsolicited, id from the async counter
			C_MSG_GPIO: begin
				f[0] = C_MSG_GPIO;
				f[1] = async_id;
				f[2] = 8'd1;
				f[3] = pads;
			end
			default: ;
		endcase
		return f;
	endfunction

	// Returns at mid stop bit, line stays high
	task automatic send_byte(input logic [7:0] b);
		uart_rx = 1'b0;
		repeat (bit_cycles) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx = b[i];
			repeat (bit_cycles) @(negedge clk);
		end
		uart_rx = 1'b1;
		repeat (bit_cycles / 2) @(negedge clk);
	endtask

	// Payload goes out high byte first
	task automatic send_frame(input logic [7:0] cmd, input logic [7:0] evt, input int plen,
		input logic [15:0] payload);
		logic [7:0] bytes[$];
		bytes = {cmd, evt, 8'(plen)};
		if (plen > 0)
			bytes.push_back(payload[15:8]);
		if (plen > 1)
			bytes.push_back(payload[7:0]);
		@(negedge clk);
		foreach (bytes[i]) begin
			// Rest of the previous stop bit
			if (i != 0)
				repeat (bit_cycles - bit_cycles / 2) @(negedge clk);
			send_byte(bytes[i]);
		end
	endtask

	// Samples each bit near its middle
	task automatic receive_byte(output logic [7:0] b);
		int t;
		t = 0;
		b = '0;
		while (uart_tx !== 1'b0) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("Timed out waiting for a start bit on the DUT tx line");
		end
		repeat (bit_cycles / 2) @(negedge clk);
		assert (uart_tx === 1'b0) else
			abort_run("Start bit on the DUT tx line ended before mid-bit");
		for (int i = 0; i < 8; i++) begin
			repeat (bit_cycles) @(negedge clk);
			b[i] = uart_tx;
		end
		repeat (bit_cycles) @(negedge clk);
		assert (uart_tx === 1'b1) else
			abort_run("Stop bit on the DUT tx line was low");
	endtask

	task automatic receive_frame(output frame_t f);
		logic [7:0] b;
		int len;
		f = '0;
		for (int i = 0; i < 3; i++) begin
			receive_byte(b);
			f[i] = b;
		end
		// Oversized lengths show up as a mismatch
		len = (f[2] > 8'd3) ? 3 : int'(f[2]);
		for (int i = 0; i < len; i++) begin
			receive_byte(b);
			f[3 + i] = b;
		end
	endtask

	task automatic run_command(input logic [7:0] cmd, input int plen,
		input logic [15:0] payload);
		logic [7:0] evt;
		frame_t got;
		evt = 8'(random_bits(8));
		exp_q.push_back(expected_frame(cmd, evt, plen, pad_model_value(), async_count));
		send_frame(cmd, evt, plen, payload);
		receive_frame(got);
		got_q.push_back(got);
		sent_frames++;
	endtask

	// Flip one input pad and collect the pin report
	task automatic toggle_and_expect(input int pin);
		frame_t got;
		@(negedge clk);
		pad_value[pin] = ~pad_value[pin];
		exp_q.push_back(expected_frame(C_MSG_GPIO, 8'h00, 1, pad_model_value(), async_count));
		async_count++;
		receive_frame(got);
		got_q.push_back(got);
		sent_frames++;
	endtask

	initial begin : compare_frames
		frame_t got;
		frame_t want;
		forever begin
			@(negedge clk);
			if (got_q.size() > 0) begin
				got = got_q.pop_front();
				want = exp_q.pop_front();
				assert (got === want) else
					abort_run($sformatf("[ERROR] %0t ns: frame %h, expected %h",
						$time, got, want));
				checked_frames++;
			end
		end
	end

	initial begin : stimulus
		logic [7:0] dir;
		logic [7:0] level;
		logic [7:0] extra;
		int pin;
		int t;
		reset = 1'b1;
		uart_rx = 1'b1;
		bit_cycles = START_BAUD;
		lfsr_state = LFSR_SEED;
		async_count = '0;
		dir_model = '0;
		level_model = '0;
		sent_frames = 0;
		checked_frames = 0;
		pad_drive = '1;
		pad_value = 8'(random_bits(8));
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		// Version query
		run_command(C_VERSION, 0, 16'h0000);

		// NAK cases
		run_command(C_UNKNOWN, 0, 16'h0000);
		extra = 8'(random_bits(8));
		run_command(C_VERSION, 1, {extra, 8'h00});

		// Pad 7 kept as an input for the interrupt test
		dir = 8'(random_bits(8)) & 8'h7f;
		level = 8'(random_bits(8));
		pad_drive = ~dir;
		dir_model = dir;
		level_model = level;
		run_command(C_GPIO_OUT, 2, {dir, level});
		assert ((gpio & dir) === (level & dir)) else
			abort_run($sformatf("[ERROR] %0t ns: output pads %h, expected %h",
				$time, gpio & dir, level & dir));
		pad_value = 8'(random_bits(8));
		run_command(C_GPIO_READ, 0, 16'h0000);

		// Lowest input pin
		pin = 7;
		for (int i = 7; i >= 0; i--) begin
			if (!dir[i])
				pin = i;
		end
		run_command(C_GPIO_INT, 1, {8'(1 << pin), 8'h00});
		toggle_and_expect(pin);
		toggle_and_expect(pin);

		// ACK still at the old rate, new divider after its stop bit
		run_command(C_BAUD, 2, 16'(NEW_BAUD));
		repeat (2 * bit_cycles) @(negedge clk);
		bit_cycles = NEW_BAUD;
		run_command(C_VERSION, 0, 16'h0000);

		t = 0;
		while (checked_frames < sent_frames) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("Received frames were left unchecked");
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: vlog.f
rtl/ice_pkg.sv
rtl/uart.sv
rtl/ice_bus_controller.sv
rtl/basics_int.sv
rtl/gpio_int.sv
rtl/ice_bus.sv
tb/ice_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ice_bus_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
